//--- qla_core.f
+incdir+test
verilog/qla_pkg.sv
verilog/sample_buffer.sv
verilog/sample_sequencer.sv
verilog/bus_timer.sv
verilog/motor_reg_file.sv
verilog/qla_core.sv
test/tb_qla_core.sv

//--- Makefile
TOOL   = verilator
TOP    = tb_qla_core
FLIST  = qla_core.f
OBJDIR = obj_dir
FLAGS  = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJDIR)

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) -f $(FLIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- test/tb_qla_model.svh
logic [DAC_WIDTH-1:0] m_setpoint [NUM_CHAN];   // Stored values, not gated
logic [DAC_WIDTH-1:0] m_staging [NUM_CHAN];
logic [NUM_CHAN-1:0]  m_staged;                // Staged since last commit
logic [REG_WIDTH-1:0] m_timestamp;
logic [REG_WIDTH-1:0] m_period;
logic [REG_WIDTH-1:0] m_quiet;                 // Edges since last reg_wen or blk_wen
logic                 m_timeout;
int                   m_phase;                 // -1 idle, else busy cycle index
logic [REG_WIDTH-1:0] m_buf [SAMPLE_DEPTH];
logic                 m_buf_valid;             // One full capture done
logic [REG_WIDTH-1:0] m_rdata;
logic [REG_WIDTH-1:0] m_srdata;

// DAC value as seen outside, zero on timeout
function automatic logic [DAC_WIDTH-1:0] gated(int i);
    return m_timeout ? '0 : m_setpoint[i];
endfunction

function automatic logic [NUM_CHAN-1:0][DAC_WIDTH-1:0] model_dac();
    logic [NUM_CHAN-1:0][DAC_WIDTH-1:0] d;
    for (int i = 0; i < NUM_CHAN; i++)
        d[i] = gated(i);
    return d;
endfunction

task automatic model_reset();
    for (int i = 0; i < NUM_CHAN; i++) begin
        m_setpoint[i] = '0;
        m_staging[i]  = '0;
    end
    for (int i = 0; i < SAMPLE_DEPTH; i++)
        m_buf[i] = '0;
    m_staged    = '0;
    m_timestamp = '0;
    m_period    = '0;
    m_quiet     = '0;
    m_timeout   = 1'b0;
    m_phase     = -1;
    m_buf_valid = 1'b0;
    m_rdata     = '0;
    m_srdata    = '0;
endtask

// One rising edge, inputs as sampled there, all reads from the old state
task automatic model_step();
    int                   wc;
    int                   rc;
    logic [3:0]           wo;
    logic [3:0]           ro;
    logic [REG_WIDTH-1:0] rd;
    logic [REG_WIDTH-1:0] quiet_nxt;
    wc = int'(reg_waddr[7:4]);                 // Upper bits ignored
    wo = reg_waddr[3:0];
    rc = int'(reg_raddr[7:4]);
    ro = reg_raddr[3:0];
    rd = '0;
    if (rc == 0) begin
        if (ro == OFS_STATUS) begin
            rd[0] = m_timeout;
            rd[1] = (m_phase >= 0);
        end else if (ro == OFS_WDOG_PERIOD) begin
            rd = m_period;
        end else if (ro == OFS_TIMESTAMP) begin
            rd = m_timestamp;
        end
    end else if (rc <= NUM_CHAN) begin
        if (ro == OFS_SETPOINT)
            rd = REG_WIDTH'(m_setpoint[rc - 1]);
        else if (ro == OFS_FEEDBACK)
            rd = REG_WIDTH'(feedback[rc - 1]);
    end
    m_rdata  = rd;
    m_srdata = (int'(sample_raddr) < SAMPLE_DEPTH) ? m_buf[int'(sample_raddr)] : '0;
    // Capture word for this busy cycle
    if (m_phase == 0)
        m_buf[0] = m_timestamp;
    else if (m_phase > 0)
        m_buf[m_phase] = {feedback[m_phase - 1], gated(m_phase - 1)};
    if (m_phase < 0) begin
        if (sample_start)
            m_phase = 0;
    end else if (m_phase == NUM_CHAN) begin
        m_phase     = -1;
        m_buf_valid = 1'b1;
    end else begin
        m_phase++;
    end
    quiet_nxt = (reg_wen || blk_wen) ? '0 : m_quiet + 1;
    if (reg_wen && wc == 0 && wo == OFS_STATUS && reg_wdata[0])
        m_timeout = 1'b0;
    else if (m_period != '0 && quiet_nxt == m_period)
        m_timeout = 1'b1;
    m_quiet = quiet_nxt;
    if (reg_wen && wc == 0 && wo == OFS_WDOG_PERIOD)
        m_period = reg_wdata;
    for (int i = 0; i < NUM_CHAN; i++) begin
        if (blk_wen && m_staged[i])
            m_setpoint[i] = m_staging[i];      // Commit beats host write
        else if (reg_wen && wo == OFS_SETPOINT && wc == i + 1)
            m_setpoint[i] = reg_wdata[DAC_WIDTH-1:0];
        if (rt_wen && int'(rt_waddr) == i + 1) begin
            m_staging[i] = rt_wdata;
            m_staged[i]  = 1'b1;
        end else if (blk_wen) begin
            m_staged[i] = 1'b0;
        end
    end
    m_timestamp = m_timestamp + 1;
endtask

//--- test/tb_qla_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_qla_core import qla_pkg::*; ();

    localparam int RUN_CYCLES = 3000;
    localparam int CLK_PERIOD = 10;

    logic                               sysclk;
    logic                               rst;
    logic [ADDR_WIDTH-1:0]              reg_raddr;
    logic [ADDR_WIDTH-1:0]              reg_waddr;
    logic [REG_WIDTH-1:0]               reg_wdata;
    logic                               reg_wen;
    logic                               blk_wen;
    logic [REG_WIDTH-1:0]               reg_rdata;
    logic                               rt_wen;
    logic [CHAN_WIDTH-1:0]              rt_waddr;
    logic [DAC_WIDTH-1:0]               rt_wdata;
    logic                               sample_start;
    logic [SAMPLE_AWIDTH-1:0]           sample_raddr;
    logic                               sample_busy;
    logic [REG_WIDTH-1:0]               sample_rdata;
    logic [NUM_CHAN-1:0][FB_WIDTH-1:0]  feedback;
    logic [NUM_CHAN-1:0][DAC_WIDTH-1:0] dac_setpoint;
    logic                               wdog_timeout;

    integer      seed = 65;
    int          cycles;                       // Edges since reset release
    logic [31:0] r;
    logic        busy_seen;                    // sample_busy at last check

    `include "tb_qla_model.svh"

    qla_core i_qla_core (
        .sysclk       (sysclk),
        .rst          (rst),
        .reg_raddr    (reg_raddr),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .blk_wen      (blk_wen),
        .reg_rdata    (reg_rdata),
        .rt_wen       (rt_wen),
        .rt_waddr     (rt_waddr),
        .rt_wdata     (rt_wdata),
        .sample_start (sample_start),
        .sample_raddr (sample_raddr),
        .sample_busy  (sample_busy),
        .sample_rdata (sample_rdata),
        .feedback     (feedback),
        .dac_setpoint (dac_setpoint),
        .wdog_timeout (wdog_timeout)
    );

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    task automatic check_reg(string name, logic [REG_WIDTH-1:0] exp,
                             logic [REG_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Test failures found");
            $fatal(1, "Register value mismatch");
        end
    endtask

    task automatic check_dac(string name, logic [NUM_CHAN-1:0][DAC_WIDTH-1:0] exp,
                             logic [NUM_CHAN-1:0][DAC_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Test failures found");
            $fatal(1, "DAC output mismatch");
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Test failures found");
            $fatal(1, "Status flag mismatch");
        end
    endtask

    // Outputs settle by the falling edge
    task automatic check_outputs();
        check_dac("dac_setpoint", model_dac(), dac_setpoint);
        check_flag("wdog_timeout", m_timeout, wdog_timeout);
        check_flag("sample_busy", m_phase >= 0, sample_busy);
        check_reg("reg_rdata", m_rdata, reg_rdata);
        if (m_buf_valid)
            check_reg("sample_rdata", m_srdata, sample_rdata);    // Buffer words defined
    endtask

    // Check, step the model on the edge, drop strobes, new feedback
    task automatic next_cycle();
        @(negedge sysclk);
        check_outputs();
        busy_seen = sample_busy;
        @(posedge sysclk);
        model_step();
        cycles++;
        reg_wen      <= 1'b0;
        blk_wen      <= 1'b0;
        rt_wen       <= 1'b0;
        sample_start <= 1'b0;
        for (int i = 0; i < NUM_CHAN; i++)
            feedback[i] <= FB_WIDTH'($random(seed));
    endtask

    // Random upper bits, the DUT must ignore them
    function automatic logic [ADDR_WIDTH-1:0] make_addr(int chan, logic [3:0] ofs);
        logic [31:0] hi;
        hi = $random(seed);
        return {hi[7:0], CHAN_WIDTH'(chan), ofs};
    endfunction

    // Capture, retrigger while busy, then read all words and one past the end
    task automatic run_sample();
        int waited;
        waited = 0;
        sample_start <= 1'b1;
        next_cycle();
        do begin
            r = $random(seed);
            if (r[0])
                sample_start <= 1'b1;          // Must not stretch busy
            next_cycle();
            waited++;
            if (waited > SAMPLE_DEPTH + 2) begin
                $display("Test failures found");
                $fatal(1, "Sample capture never left busy");
            end
        end while (busy_seen);
        for (int w = 0; w <= SAMPLE_DEPTH; w++) begin
            sample_raddr <= SAMPLE_AWIDTH'(w);
            next_cycle();
        end
    endtask

    initial begin
        sysclk       = 1'b0;
        rst          = 1'b1;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wen      = 1'b0;
        rt_wen       = 1'b0;
        rt_waddr     = '0;
        rt_wdata     = '0;
        sample_start = 1'b0;
        sample_raddr = '0;
        feedback     = '0;
        cycles       = 0;
        busy_seen    = 1'b0;
        model_reset();
        repeat (10) @(posedge sysclk);
        rst <= 1'b0;
        while (cycles < RUN_CYCLES) begin
            next_cycle();                      // First pass checks the reset state
            r = $random(seed);
            case (r[3:0])
                4'd6, 4'd7: begin              // Setpoint or feedback offset, any channel
                    reg_waddr <= make_addr(int'(r[15:8]) % (NUM_CHAN + 1), {3'b0, r[4]});
                    reg_wdata <= $random(seed);
                    reg_wen   <= 1'b1;
                end
                4'd8: begin
                    rt_waddr <= CHAN_WIDTH'(1 + int'(r[15:8]) % NUM_CHAN);
                    rt_wdata <= r[31:16];
                    rt_wen   <= 1'b1;
                end
                4'd9: blk_wen <= 1'b1;
                4'd10: begin                   // Timeout clear
                    reg_waddr <= make_addr(0, OFS_STATUS);
                    reg_wdata <= 32'h1;
                    reg_wen   <= 1'b1;
                end
                4'd11: begin                   // Short periods so timeouts happen
                    reg_waddr <= make_addr(0, OFS_WDOG_PERIOD);
                    reg_wdata <= REG_WIDTH'(r[6:4]);
                    reg_wen   <= 1'b1;
                end
                4'd12, 4'd13, 4'd14: begin
                    reg_raddr <= make_addr(int'(r[15:8]) % (NUM_CHAN + 1), {1'b0, r[6:4]});
                end
                4'd15: run_sample();
                default: ;                     // Idle
            endcase
        end
        next_cycle();
        $display("All tests passed!");
        $finish;
    end

    // Run limit from the cycle budget plus room for captures
    initial begin
        @(negedge rst);
        #((RUN_CYCLES + 20 * (NUM_CHAN + 1)) * CLK_PERIOD);
        $display("Test failures found");
        $fatal(1, "Simulation ran past its cycle limit");
    end

endmodule

`default_nettype wire

//--- verilog/qla_core.sv
`timescale 1ns/10ps
`default_nettype none

module qla_core import qla_pkg::*; (
    input  logic                               sysclk,
    input  logic                               rst,
    // Host register bus
    input  logic [ADDR_WIDTH-1:0]              reg_raddr,
    input  logic [ADDR_WIDTH-1:0]              reg_waddr,
    input  logic [REG_WIDTH-1:0]               reg_wdata,
    input  logic                               reg_wen,
    input  logic                               blk_wen,
    output logic [REG_WIDTH-1:0]               reg_rdata,
    // Real-time write
    input  logic                               rt_wen,
    input  logic [CHAN_WIDTH-1:0]              rt_waddr,
    input  logic [DAC_WIDTH-1:0]               rt_wdata,
    // Data sampling
    input  logic                               sample_start,
    input  logic [SAMPLE_AWIDTH-1:0]           sample_raddr,
    output logic                               sample_busy,
    output logic [REG_WIDTH-1:0]               sample_rdata,
    // Converters
    input  logic [NUM_CHAN-1:0][FB_WIDTH-1:0]  feedback,
    output logic [NUM_CHAN-1:0][DAC_WIDTH-1:0] dac_setpoint,
    output logic                               wdog_timeout
);

    logic [REG_WIDTH-1:0]     timestamp;       // Free-running, also stamped into samples
    logic [REG_WIDTH-1:0]     wdog_period;
    logic                     wdog_clear;      // Status write with bit 0 set
    logic [CHAN_WIDTH-1:0]    sample_chan;     // Channel the sampler is reading
    logic [DAC_WIDTH-1:0]     chan_setpoint;
    logic [FB_WIDTH-1:0]      chan_feedback;
    logic                     buf_wen;
    logic [SAMPLE_AWIDTH-1:0] buf_waddr;
    logic [REG_WIDTH-1:0]     buf_wdata;

    motor_reg_file i_motor_reg_file (
        .sysclk        (sysclk),
        .rst           (rst),
        .reg_raddr     (reg_raddr),
        .reg_waddr     (reg_waddr),
        .reg_wdata     (reg_wdata),
        .reg_wen       (reg_wen),
        .blk_wen       (blk_wen),
        .reg_rdata     (reg_rdata),
        .rt_wen        (rt_wen),
        .rt_waddr      (rt_waddr),
        .rt_wdata      (rt_wdata),
        .feedback      (feedback),
        .dac_setpoint  (dac_setpoint),
        .timestamp     (timestamp),
        .wdog_period   (wdog_period),
        .wdog_timeout  (wdog_timeout),
        .wdog_clear    (wdog_clear),
        .sample_busy   (sample_busy),
        .sample_chan   (sample_chan),
        .chan_setpoint (chan_setpoint),
        .chan_feedback (chan_feedback)
    );

    bus_timer i_bus_timer (
        .sysclk       (sysclk),
        .rst          (rst),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .blk_wen      (blk_wen),
        .wdog_clear   (wdog_clear),
        .timestamp    (timestamp),
        .wdog_period  (wdog_period),
        .wdog_timeout (wdog_timeout)
    );

    sample_sequencer i_sample_sequencer (
        .sysclk        (sysclk),
        .rst           (rst),
        .sample_start  (sample_start),
        .timestamp     (timestamp),
        .chan_setpoint (chan_setpoint),
        .chan_feedback (chan_feedback),
        .sample_busy   (sample_busy),
        .sample_chan   (sample_chan),
        .buf_wen       (buf_wen),
        .buf_waddr     (buf_waddr),
        .buf_wdata     (buf_wdata)
    );

    sample_buffer i_sample_buffer (
        .sysclk       (sysclk),
        .buf_wen      (buf_wen),
        .buf_waddr    (buf_waddr),
        .buf_wdata    (buf_wdata),
        .sample_raddr (sample_raddr),
        .sample_rdata (sample_rdata)
    );

endmodule

`default_nettype wire

//--- verilog/motor_reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module motor_reg_file import qla_pkg::*; (
    input  logic                               sysclk,
    input  logic                               rst,
    // Host register bus
    input  logic [ADDR_WIDTH-1:0]              reg_raddr,
    input  logic [ADDR_WIDTH-1:0]              reg_waddr,
    input  logic [REG_WIDTH-1:0]               reg_wdata,
    input  logic                               reg_wen,
    input  logic                               blk_wen,     // Commit staged setpoints
    output logic [REG_WIDTH-1:0]               reg_rdata,
    // Real-time staging
    input  logic                               rt_wen,
    input  logic [CHAN_WIDTH-1:0]              rt_waddr,    // 1..NUM_CHAN
    input  logic [DAC_WIDTH-1:0]               rt_wdata,
    // Converters
    input  logic [NUM_CHAN-1:0][FB_WIDTH-1:0]  feedback,
    output logic [NUM_CHAN-1:0][DAC_WIDTH-1:0] dac_setpoint,
    // Board registers kept elsewhere
    input  logic [REG_WIDTH-1:0]               timestamp,
    input  logic [REG_WIDTH-1:0]               wdog_period,
    input  logic                               wdog_timeout,
    output logic                               wdog_clear,
    input  logic                               sample_busy,
    // Sampler port
    input  logic [CHAN_WIDTH-1:0]              sample_chan,
    output logic [DAC_WIDTH-1:0]               chan_setpoint, // Gated value
    output logic [FB_WIDTH-1:0]                chan_feedback
);

    logic [DAC_WIDTH-1:0]  setpoint [NUM_CHAN];   // Active setpoints
    logic [DAC_WIDTH-1:0]  staging [NUM_CHAN];    // Real-time staged values
    logic [NUM_CHAN-1:0]   staged;                // Stage pending for commit
    logic [CHAN_WIDTH-1:0] wchan;
    logic [OFS_WIDTH-1:0]  wofs;
    logic [CHAN_WIDTH-1:0] rchan;
    logic [OFS_WIDTH-1:0]  rofs;
    logic                  sp_wen;                // Setpoint write, channel still open
    logic [REG_WIDTH-1:0]  rd_mux;

    assign wchan = reg_waddr[CHAN_LSB +: CHAN_WIDTH];
    assign wofs  = reg_waddr[OFS_WIDTH-1:0];
    assign rchan = reg_raddr[CHAN_LSB +: CHAN_WIDTH];
    assign rofs  = reg_raddr[OFS_WIDTH-1:0];

    assign sp_wen = reg_wen && (wofs == OFS_SETPOINT);
    // Channel 0 offset 0 is the status register
    assign wdog_clear = reg_wen && (wchan == '0) && (wofs == OFS_STATUS)
                        && reg_wdata[STAT_TIMEOUT];

    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                setpoint[i] <= '0;
                staging[i]  <= '0;
            end
            staged <= '0;
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (blk_wen && staged[i])
                    setpoint[i] <= staging[i];            // Commit wins over host write
                else if (sp_wen && wchan == CHAN_WIDTH'(i + 1))
                    setpoint[i] <= reg_wdata[DAC_WIDTH-1:0];
                if (rt_wen && rt_waddr == CHAN_WIDTH'(i + 1)) begin
                    staging[i] <= rt_wdata;
                    staged[i]  <= 1'b1;                   // Held for the next commit
                end else if (blk_wen) begin
                    staged[i] <= 1'b0;
                end
            end
        end
    end

    // DAC drive and sampler view, both zeroed on timeout
    always_comb begin
        chan_setpoint = '0;
        chan_feedback = '0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            dac_setpoint[i] = wdog_timeout ? '0 : setpoint[i];
            if (sample_chan == CHAN_WIDTH'(i + 1)) begin
                chan_setpoint = wdog_timeout ? '0 : setpoint[i];
                chan_feedback = feedback[i];
            end
        end
    end

    always_comb begin
        rd_mux = '0;                                      // Unmapped reads give 0
        if (rchan == '0) begin
            case (rofs)
                OFS_STATUS: begin
                    rd_mux[STAT_TIMEOUT] = wdog_timeout;
                    rd_mux[STAT_BUSY]    = sample_busy;
                end
                OFS_WDOG_PERIOD: rd_mux = wdog_period;
                OFS_TIMESTAMP:   rd_mux = timestamp;
                default:         rd_mux = '0;
            endcase
        end
        for (int i = 0; i < NUM_CHAN; i++) begin
            if (rchan == CHAN_WIDTH'(i + 1)) begin
                if (rofs == OFS_SETPOINT)
                    rd_mux = REG_WIDTH'(setpoint[i]);     // Stored value, not gated
                else if (rofs == OFS_FEEDBACK)
                    rd_mux = REG_WIDTH'(feedback[i]);
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst)
            reg_rdata <= '0;
        else
            reg_rdata <= rd_mux;                          // One cycle read latency
    end

    // Staging source only ever addresses a motor channel
    a_rt_chan: assert property (@(posedge sysclk) disable iff (rst)
        rt_wen |-> (rt_waddr != '0) && (rt_waddr <= CHAN_WIDTH'(NUM_CHAN)));

endmodule

`default_nettype wire

//--- verilog/bus_timer.sv
`timescale 1ns/10ps
`default_nettype none

module bus_timer import qla_pkg::*; (
    input  logic                  sysclk,
    input  logic                  rst,
    input  logic [ADDR_WIDTH-1:0] reg_waddr,
    input  logic [REG_WIDTH-1:0]  reg_wdata,
    input  logic                  reg_wen,
    input  logic                  blk_wen,
    input  logic                  wdog_clear,     // From status register write
    output logic [REG_WIDTH-1:0]  timestamp,
    output logic [REG_WIDTH-1:0]  wdog_period,    // Cycles, 0 = off
    output logic                  wdog_timeout    // Sticky
);

    logic [REG_WIDTH-1:0] wdog_cnt;               // Cycles since host activity
    logic [REG_WIDTH-1:0] wdog_cnt_nxt;
    logic                 host_active;
    logic                 period_wen;
    logic                 wdog_hit;

    // Board register, never overlaps the motor channels
    assign period_wen = reg_wen && (reg_waddr[CHAN_LSB +: CHAN_WIDTH] == '0)
                        && (reg_waddr[OFS_WIDTH-1:0] == OFS_WDOG_PERIOD);

    assign host_active  = reg_wen || blk_wen;     // Any write feeds the watchdog
    assign wdog_cnt_nxt = host_active ? '0 : wdog_cnt + 1'b1;

    // Period edges after the last write
    assign wdog_hit = (wdog_period != '0) && (wdog_cnt_nxt == wdog_period);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            timestamp    <= '0;
            wdog_period  <= '0;
            wdog_cnt     <= '0;
            wdog_timeout <= 1'b0;
        end else begin
            timestamp <= timestamp + 1'b1;        // Every edge
            wdog_cnt  <= wdog_cnt_nxt;
            if (period_wen)
                wdog_period <= reg_wdata;
            if (wdog_clear)
                wdog_timeout <= 1'b0;
            else if (wdog_hit)
                wdog_timeout <= 1'b1;
        end
    end

    // Period writes restart the count so a fresh timeout sees a live period
    a_wdog_off: assert property (@(posedge sysclk) disable iff (rst)
        $rose(wdog_timeout) |-> wdog_period != '0);

endmodule

`default_nettype wire

//--- verilog/sample_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module sample_sequencer import qla_pkg::*; (
    input  logic                     sysclk,
    input  logic                     rst,
    input  logic                     sample_start,
    input  logic [REG_WIDTH-1:0]     timestamp,
    input  logic [DAC_WIDTH-1:0]     chan_setpoint,   // Gated DAC value of sample_chan
    input  logic [FB_WIDTH-1:0]      chan_feedback,
    output logic                     sample_busy,
    output logic [CHAN_WIDTH-1:0]    sample_chan,
    output logic                     buf_wen,
    output logic [SAMPLE_AWIDTH-1:0] buf_waddr,
    output logic [REG_WIDTH-1:0]     buf_wdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STAMP,        // Word 0, timestamp
        ST_CHAN          // Words 1..NUM_CHAN
    } seq_state_t;

    seq_state_t state;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            state       <= ST_IDLE;
            sample_chan <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (sample_start)
                        state <= ST_STAMP;
                end
                ST_STAMP: begin
                    state       <= ST_CHAN;
                    sample_chan <= CHAN_WIDTH'(1);
                end
                ST_CHAN: begin
                    if (sample_chan == CHAN_WIDTH'(NUM_CHAN)) begin
                        state       <= ST_IDLE;   // Last channel written
                        sample_chan <= '0;
                    end else begin
                        sample_chan <= sample_chan + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Start while busy falls through, only idle looks at it
    assign sample_busy = (state != ST_IDLE);
    assign buf_wen     = sample_busy;             // One word per busy cycle
    assign buf_waddr   = SAMPLE_AWIDTH'(sample_chan);   // 0 during stamp

    // Feedback high, setpoint low
    assign buf_wdata = (state == ST_STAMP) ? timestamp
                                           : {chan_feedback, chan_setpoint};

    // Busy window is one buffer pass
    a_busy_len: assert property (@(posedge sysclk) disable iff (rst)
        $fell(sample_busy) |->
            $past(sample_busy, SAMPLE_DEPTH) && !$past(sample_busy, SAMPLE_DEPTH + 1));

endmodule

`default_nettype wire

//--- verilog/sample_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module sample_buffer import qla_pkg::*; (
    input  logic                     sysclk,
    input  logic                     buf_wen,
    input  logic [SAMPLE_AWIDTH-1:0] buf_waddr,
    input  logic [REG_WIDTH-1:0]     buf_wdata,
    input  logic [SAMPLE_AWIDTH-1:0] sample_raddr,   // Host side
    output logic [REG_WIDTH-1:0]     sample_rdata
);

    logic [REG_WIDTH-1:0] mem [SAMPLE_DEPTH];       // Timestamp then channels
    logic [REG_WIDTH-1:0] rd_word;

    always_ff @(posedge sysclk) begin
        for (int i = 0; i < SAMPLE_DEPTH; i++) begin
            if (buf_wen && buf_waddr == SAMPLE_AWIDTH'(i))
                mem[i] <= buf_wdata;
        end
    end

    // Out of range addresses read 0
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < SAMPLE_DEPTH; i++) begin
            if (sample_raddr == SAMPLE_AWIDTH'(i))
                rd_word = mem[i];
        end
    end

    always_ff @(posedge sysclk) begin
        sample_rdata <= rd_word;                    // One cycle latency
    end

endmodule

`default_nettype wire

//--- verilog/qla_pkg.sv
`default_nettype none

package qla_pkg;

    // Board geometry
    localparam int NUM_CHAN   = 4;              // Motor channels on the QLA
    localparam int CHAN_WIDTH = 4;              // Channel field of an address

    // Host register bus
    localparam int REG_WIDTH  = 32;
    localparam int ADDR_WIDTH = 16;

    // Converter words, parallel here
    localparam int DAC_WIDTH  = 16;
    localparam int FB_WIDTH   = 16;

    // Address split: channel in bits 7..4, offset in bits 3..0
    localparam int OFS_WIDTH  = 4;
    localparam int CHAN_LSB   = OFS_WIDTH;

    // Per-channel offsets, channels 1..NUM_CHAN
    localparam logic [OFS_WIDTH-1:0] OFS_SETPOINT    = 4'd0;   // Active setpoint, R/W
    localparam logic [OFS_WIDTH-1:0] OFS_FEEDBACK    = 4'd1;   // Feedback, RO

    // Board offsets, channel 0
    localparam logic [OFS_WIDTH-1:0] OFS_STATUS      = 4'd0;
    localparam logic [OFS_WIDTH-1:0] OFS_WDOG_PERIOD = 4'd3;   // 0 disables watchdog
    localparam logic [OFS_WIDTH-1:0] OFS_TIMESTAMP   = 4'd4;   // RO

    // Status register bits
    localparam int STAT_TIMEOUT = 0;            // Write 1 to clear
    localparam int STAT_BUSY    = 1;

    // Sample buffer, timestamp word then one word per channel
    localparam int SAMPLE_DEPTH  = NUM_CHAN + 1;
    localparam int SAMPLE_AWIDTH = 6;

endpackage

`default_nettype wire
